/* Makefile */
# Verilator build and run of the DAQ testbench

VERILATOR ?= verilator
TOP       ?= tbDaq
FILELIST  ?= tb.f
OBJDIR    ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
LINTFLAGS ?= --lint-only --timing
PASSMSG   ?= sim passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)

# Pass only if the pass line shows up in the output
run: build
	@out="$$(./$(OBJDIR)/V$(TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASSMSG)"

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJDIR)

/* source/daqControl.sv */
module daqControl (
    input  logic                        Clk,
    input  logic                        arstN,
    input  daqPkg::apbReq_t             apbReq,
    output daqPkg::apbRsp_t             apbRsp,
    output logic                        scLoad,
    output daqPkg::scConfig_t           scWord,
    input  logic                        scDone,
    output logic                        markerReq,
    output logic [daqPkg::dacBits-1:0]  markerDac,
    output logic                        startAcq,
    output logic                        startReadout,
    input  logic                        endReadout,
    input  logic [daqPkg::wordBits-1:0] fifoHead,
    input  logic                        fifoEmpty,
    input  logic                        overflow,
    output logic                        pop
);
    typedef enum logic [2:0] {
        stIdle, stLoad, stWaitSc, stMarker, stAcq, stReadout, stWaitEnd
    } ctrlState_t;

    ctrlState_t                 state;
    logic                       sweepMode;   // 0 = single config load
    logic [daqPkg::dacBits-1:0] stepDac;     // DAC0 code of current step
    logic [15:0]                acqCnt;      // Window cycles left
    logic                       busy;
    logic                       apbWrite, apbRead;
    logic                       ctrlWrite, loadGo, sweepGo;

    // Slow-control and sweep settings
    logic [7:0]                 header;
    logic [5:0]                 ctestChannel;
    logic [daqPkg::dacBits-1:0] dac0, dac1, dac2;
    logic [daqPkg::dacBits-1:0] startDac, endDac;
    logic [15:0]                acqTime;

    //////////////////////////////////////////////////
    // APB slave with zero wait states
    //////////////////////////////////////////////////
    assign apbWrite  = apbReq.psel & apbReq.penable & apbReq.pwrite;
    assign apbRead   = apbReq.psel & apbReq.penable & ~apbReq.pwrite;
    assign ctrlWrite = apbWrite && apbReq.paddr == daqPkg::addrCtrl && !busy;
    assign sweepGo   = ctrlWrite & apbReq.pwdata[1];  // Sweep wins over load
    assign loadGo    = ctrlWrite & apbReq.pwdata[0];

    always_ff @(posedge Clk or negedge arstN) begin
        if (!arstN) begin
            header       <= '0;
            ctestChannel <= '0;
            dac0         <= '0;
            dac1         <= '0;
            dac2         <= '0;
            startDac     <= '0;
            endDac       <= '0;
            acqTime      <= 16'd1;
        end else if (apbWrite) begin
            case (apbReq.paddr)
                daqPkg::addrHeader: begin
                    header       <= apbReq.pwdata[7:0];
                    ctestChannel <= apbReq.pwdata[13:8];
                end
                daqPkg::addrDac0:    dac0 <= apbReq.pwdata[9:0];
                daqPkg::addrDac12: begin
                    dac1 <= apbReq.pwdata[9:0];
                    dac2 <= apbReq.pwdata[25:16];
                end
                daqPkg::addrSweep: begin
                    startDac <= apbReq.pwdata[9:0];
                    endDac   <= apbReq.pwdata[25:16];
                end
                daqPkg::addrAcqTime: acqTime <= apbReq.pwdata[15:0];
                default: ;
            endcase
        end
    end

    always_comb begin
        apbRsp.pready = 1'b1;  // Never stalls
        apbRsp.prdata = '0;
        case (apbReq.paddr)
            daqPkg::addrStatus:  apbRsp.prdata = {29'd0, overflow, fifoEmpty, busy};
            daqPkg::addrHeader:  apbRsp.prdata = {18'd0, ctestChannel, header};
            daqPkg::addrDac0:    apbRsp.prdata = {22'd0, dac0};
            daqPkg::addrDac12:   apbRsp.prdata = {6'd0, dac2, 6'd0, dac1};
            daqPkg::addrSweep:   apbRsp.prdata = {6'd0, endDac, 6'd0, startDac};
            daqPkg::addrAcqTime: apbRsp.prdata = {16'd0, acqTime};
            daqPkg::addrFifo: begin
                if (!fifoEmpty) apbRsp.prdata = {16'd0, fifoHead};  // Empty reads zero
            end
            default: ;
        endcase
    end

    assign pop = apbRead && apbReq.paddr == daqPkg::addrFifo && !fifoEmpty;

    //////////////////////////////////////////////////
    // Load / sweep sequencer
    //////////////////////////////////////////////////
    always_ff @(posedge Clk or negedge arstN) begin
        if (!arstN) begin
            state     <= stIdle;
            sweepMode <= 1'b0;
            stepDac   <= '0;
            acqCnt    <= '0;
        end else begin
            case (state)
                stIdle: begin
                    if (sweepGo) begin
                        sweepMode <= 1'b1;
                        stepDac   <= startDac;
                        state     <= stLoad;
                    end else if (loadGo) begin
                        sweepMode <= 1'b0;
                        stepDac   <= dac0;  // Plain load keeps register DAC0
                        state     <= stLoad;
                    end
                end
                stLoad:   state <= stWaitSc;  // scLoad pulse
                stWaitSc: begin
                    if (scDone) state <= sweepMode ? stMarker : stIdle;
                end
                stMarker: begin
                    acqCnt <= acqTime;
                    state  <= stAcq;
                end
                stAcq: begin
                    // Window is exactly acqTime cycles
                    if (acqCnt <= 16'd1) state <= stReadout;
                    else acqCnt <= acqCnt - 1'b1;
                end
                stReadout: state <= stWaitEnd;
                stWaitEnd: begin
                    if (endReadout) begin
                        if (stepDac == endDac) begin
                            state <= stIdle;  // Last code done
                        end else begin
                            stepDac <= stepDac + 1'b1;
                            state   <= stLoad;
                        end
                    end
                end
                default: state <= stIdle;
            endcase
        end
    end

    assign busy         = state != stIdle;
    assign scLoad       = state == stLoad;
    assign markerReq    = state == stMarker;
    assign markerDac    = stepDac;
    assign startAcq     = state == stAcq;
    assign startReadout = state == stReadout;
    assign scWord       = '{header: header, dac0: stepDac, dac1: dac1, dac2: dac2,
                            ctestChannel: ctestChannel};

    // A shift ends only in the wait state and never inside a window
    assert property (@(posedge Clk) disable iff (!arstN) scDone |-> state == stWaitSc);

endmodule

/* source/daqPkg.sv */
package daqPkg;

    //////////////////////////////////////////////////
    // Widths and depths
    //////////////////////////////////////////////////
    localparam int dacBits   = 10;  // Threshold DAC code
    localparam int scBits    = 44;  // Shortened slow-control word
    localparam int wordBits  = 16;  // Readout and FIFO word
    localparam int fifoDepth = 32;

    // Upper bits of a marker word, DAC code fills the rest
    localparam logic [wordBits-dacBits-1:0] markerTag = 6'b101100;

    //////////////////////////////////////////////////
    // APB register map, byte addresses
    //////////////////////////////////////////////////
    localparam logic [7:0] addrCtrl    = 8'h00;  // W: bit0 load, bit1 sweep
    localparam logic [7:0] addrStatus  = 8'h04;  // R: busy, fifoEmpty, overflow
    localparam logic [7:0] addrHeader  = 8'h08;
    localparam logic [7:0] addrDac0    = 8'h0C;
    localparam logic [7:0] addrDac12   = 8'h10;
    localparam logic [7:0] addrSweep   = 8'h14;  // startDac / endDac
    localparam logic [7:0] addrAcqTime = 8'h18;
    localparam logic [7:0] addrFifo    = 8'h1C;  // Read pops one word

    //////////////////////////////////////////////////
    // Bundles
    //////////////////////////////////////////////////
    typedef struct packed {
        logic        psel;
        logic        penable;
        logic        pwrite;
        logic [7:0]  paddr;
        logic [31:0] pwdata;
    } apbReq_t;

    typedef struct packed {
        logic [31:0] prdata;
        logic        pready;
    } apbRsp_t;

    // Bit order matches the shift order, MSB goes out first
    typedef struct packed {
        logic [7:0]         header;
        logic [dacBits-1:0] dac0;
        logic [dacBits-1:0] dac1;
        logic [dacBits-1:0] dac2;
        logic [5:0]         ctestChannel;
    } scConfig_t;

    typedef struct packed {
        logic select;    // 1 = slow-control register
        logic srRstb;    // Selected register reset, active low
        logic srCk;
        logic srIn;
        logic startAcq;
    } asicPins_t;

    typedef struct packed {
        logic                valid;
        logic [wordBits-1:0] data;
    } fifoWrite_t;

endpackage

/* source/daqTop.sv */
module daqTop (
    input  logic              Clk,
    input  logic              arstN,
    input  daqPkg::apbReq_t   apbReq,
    output daqPkg::apbRsp_t   apbRsp,
    output wire daqPkg::asicPins_t asicPins,
    output logic              startReadout,
    input  logic              dout,        // Serial data, active low
    input  logic              transmitOn,  // Low while data is sent
    input  logic              endReadout
);
    // Sequencer to shifter
    logic                          scLoad;
    daqPkg::scConfig_t             scWord;
    logic                          scDone;
    // Sequencer to framer
    logic                          markerReq;
    logic [daqPkg::dacBits-1:0]    markerDac;
    // Framer, FIFO and host side
    daqPkg::fifoWrite_t            fifoWrite;
    logic [daqPkg::wordBits-1:0]   fifoHead;
    logic                          fifoEmpty;
    logic                          overflow;
    logic                          pop;

    daqControl ctrl (
        .Clk(Clk), .arstN(arstN),
        .apbReq(apbReq), .apbRsp(apbRsp),
        .scLoad(scLoad), .scWord(scWord), .scDone(scDone),
        .markerReq(markerReq), .markerDac(markerDac),
        .startAcq(asicPins.startAcq),
        .startReadout(startReadout), .endReadout(endReadout),
        .fifoHead(fifoHead), .fifoEmpty(fifoEmpty), .overflow(overflow),
        .pop(pop)
    );

    scShifter shifter (
        .Clk(Clk), .arstN(arstN),
        .scLoad(scLoad), .scWord(scWord), .scDone(scDone),
        .select(asicPins.select),
        .srRstb(asicPins.srRstb),
        .srCk(asicPins.srCk),
        .srIn(asicPins.srIn)
    );

    readoutFramer framer (
        .Clk(Clk), .arstN(arstN),
        .markerReq(markerReq), .markerDac(markerDac),
        .dout(dout), .transmitOn(transmitOn),
        .fifoWrite(fifoWrite)
    );

    eventFifo fifo (
        .Clk(Clk), .arstN(arstN),
        .fifoWrite(fifoWrite), .pop(pop),
        .head(fifoHead), .empty(fifoEmpty),
        .full(),               // Full only matters inside, as overflow
        .overflow(overflow)
    );

endmodule

/* source/eventFifo.sv */
module eventFifo (
    input  logic                        Clk,
    input  logic                        arstN,
    input  daqPkg::fifoWrite_t          fifoWrite,
    input  logic                        pop,
    output logic [daqPkg::wordBits-1:0] head,
    output logic                        empty,
    output logic                        full,
    output logic                        overflow
);
    localparam int ptrBits = $clog2(daqPkg::fifoDepth);

    logic [daqPkg::wordBits-1:0] mem [daqPkg::fifoDepth];
    logic [ptrBits:0]            wrPtr, rdPtr;  // Extra wrap bit
    logic                        push;

    assign push  = fifoWrite.valid && !full;  // Full drops the word
    assign empty = wrPtr == rdPtr;
    assign full  = wrPtr == {~rdPtr[ptrBits], rdPtr[ptrBits-1:0]};
    assign head  = mem[rdPtr[ptrBits-1:0]];

    always_ff @(posedge Clk) begin
        if (push) mem[wrPtr[ptrBits-1:0]] <= fifoWrite.data;
    end

    always_ff @(posedge Clk or negedge arstN) begin
        if (!arstN) begin
            wrPtr    <= '0;
            rdPtr    <= '0;
            overflow <= 1'b0;
        end else begin
            if (push) wrPtr <= wrPtr + 1'b1;
            if (pop && !empty) rdPtr <= rdPtr + 1'b1;
            if (fifoWrite.valid && full) overflow <= 1'b1;  // Sticky
        end
    end

    // Host side must check fifoEmpty before popping
    assert property (@(posedge Clk) disable iff (!arstN) pop |-> !empty);

endmodule

/* source/readoutFramer.sv */
module readoutFramer (
    input  logic                       Clk,
    input  logic                       arstN,
    input  logic                       markerReq,
    input  logic [daqPkg::dacBits-1:0] markerDac,
    input  logic                       dout,        // Active low data
    input  logic                       transmitOn,  // Active low frame
    output daqPkg::fifoWrite_t         fifoWrite
);
    logic [daqPkg::wordBits-2:0]         shiftReg;  // Bits gathered so far
    logic [$clog2(daqPkg::wordBits)-1:0] bitCnt;
    logic                                dataBit;
    logic                                wordDone;
    logic                                wrValid;
    logic [daqPkg::wordBits-1:0]         wrData;

    assign dataBit  = ~dout;
    assign wordDone = !transmitOn && bitCnt == 4'(daqPkg::wordBits - 1);

    //////////////////////////////////////////////////
    // Serial to parallel, MSB first
    //////////////////////////////////////////////////
    always_ff @(posedge Clk or negedge arstN) begin
        if (!arstN) begin
            bitCnt <= '0;
        end else if (transmitOn) begin
            bitCnt <= '0;  // Partial word thrown away
        end else begin
            bitCnt <= bitCnt + 1'b1;  // Wraps after 16th bit
        end
    end

    always_ff @(posedge Clk) begin
        if (!transmitOn) shiftReg <= {shiftReg[daqPkg::wordBits-3:0], dataBit};
    end

    //////////////////////////////////////////////////
    // FIFO write port
    //////////////////////////////////////////////////
    always_ff @(posedge Clk or negedge arstN) begin
        if (!arstN) wrValid <= 1'b0;
        else wrValid <= markerReq | wordDone;
    end

    always_ff @(posedge Clk) begin
        if (markerReq) begin
            wrData <= {daqPkg::markerTag, markerDac};  // Step marker
        end else if (wordDone) begin
            wrData <= {shiftReg, dataBit};
        end
    end

    assign fifoWrite = '{valid: wrValid, data: wrData};

endmodule

/* source/scShifter.sv */
module scShifter (
    input  logic              Clk,
    input  logic              arstN,
    input  logic              scLoad,
    input  daqPkg::scConfig_t scWord,
    output logic              scDone,
    output logic              select,
    output logic              srRstb,
    output logic              srCk,
    output logic              srIn
);
    typedef enum logic [1:0] {scIdle, scReset, scShift, scEnd} scState_t;

    scState_t                            state;
    logic                                phase;   // 0 = clock low half
    logic [$clog2(daqPkg::scBits)-1:0]   bitCnt;
    logic [daqPkg::scBits-1:0]           shiftReg;
    logic                                nextBit;

    // Take the next MSB at end of reset or after a bit's high half
    assign nextBit = phase && (state == scReset ||
                     (state == scShift && bitCnt != 6'(daqPkg::scBits - 1)));

    always_ff @(posedge Clk) begin
        if (state == scIdle && scLoad) shiftReg <= scWord;
        else if (nextBit) shiftReg <= shiftReg << 1;
    end

    always_ff @(posedge Clk or negedge arstN) begin
        if (!arstN) begin
            state  <= scIdle;
            phase  <= 1'b0;
            bitCnt <= '0;
            scDone <= 1'b0;
            select <= 1'b0;
            srRstb <= 1'b1;
            srCk   <= 1'b0;
            srIn   <= 1'b0;
        end else begin
            scDone <= 1'b0;
            case (state)
                scIdle: begin
                    if (scLoad) begin
                        select <= 1'b1;
                        srRstb <= 1'b0;  // Clear selected register
                        phase  <= 1'b0;
                        state  <= scReset;
                    end
                end
                scReset: begin
                    phase <= ~phase;
                    if (phase) begin  // Second reset cycle
                        srRstb <= 1'b1;
                        srIn   <= shiftReg[daqPkg::scBits-1];
                        bitCnt <= '0;
                        phase  <= 1'b0;
                        state  <= scShift;
                    end
                end
                scShift: begin
                    if (!phase) begin
                        srCk  <= 1'b1;  // Data already stable
                        phase <= 1'b1;
                    end else begin
                        srCk  <= 1'b0;
                        phase <= 1'b0;
                        if (bitCnt == 6'(daqPkg::scBits - 1)) begin
                            scDone <= 1'b1;
                            state  <= scEnd;
                        end else begin
                            bitCnt <= bitCnt + 1'b1;
                            srIn   <= shiftReg[daqPkg::scBits-1];
                        end
                    end
                end
                scEnd: begin
                    select <= 1'b0;  // Drops after scDone
                    state  <= scIdle;
                end
                default: state <= scIdle;
            endcase
        end
    end

    // ASIC samples srIn on srCk rise
    assert property (@(posedge Clk) disable iff (!arstN) srCk |-> $stable(srIn));

endmodule

/* tb.f */
source/daqPkg.sv
source/eventFifo.sv
source/readoutFramer.sv
source/scShifter.sv
source/daqControl.sv
source/daqTop.sv
test/asicModel.sv
test/tbDaq.sv

/* test/asicModel.sv */
module asicModel (
    input  logic        Clk,
    input  logic        startReadout,
    output logic        dout,         // Active low data
    output logic        transmitOn,   // Low while bits go out
    output logic        endReadout,
    output logic [31:0] eventWord,    // Copy of the event for the checker
    output logic        eventStrobe
);
    logic [31:0] lcgState;

    // 32-bit LCG, full period modulo 2^32
    function automatic logic [31:0] lcgNext(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    initial begin
        int i;
        lcgState    = 32'd44408;  // Seed
        dout        = 1'b1;
        transmitOn  = 1'b1;
        endReadout  = 1'b0;
        eventWord   = '0;
        eventStrobe = 1'b0;
        forever begin
            @(posedge Clk);
            if (startReadout) begin
                lcgState = lcgNext(lcgState);
                eventWord   <= lcgState;
                eventStrobe <= 1'b1;
                @(posedge Clk);
                eventStrobe <= 1'b0;
                repeat (2) @(posedge Clk);  // Reply 3 cycles after the request
                for (i = 31; i >= 0; i--) begin
                    transmitOn <= 1'b0;
                    dout       <= ~lcgState[i];  // MSB first, inverted on the wire
                    @(posedge Clk);
                end
                transmitOn <= 1'b1;
                dout       <= 1'b1;
                endReadout <= 1'b1;
                @(posedge Clk);
                endReadout <= 1'b0;
            end
        end
    end

endmodule

/* test/daqPatterns.txt */
# kind: 0 config load, 1 sweep, 2 sweep that overflows the FIFO, 3 sweep with restart while busy
# kind header dac0 dac1 dac2 ctest startDac endDac acqTime eventsPerStep, all hex
0 a5 2b3 155 3ff 2a 000 000 0004 1
0 3c 000 1ff 0c8 15 000 000 0004 1
1 5a 100 120 140 07 0fa 0fd 0005 1
1 81 000 03f 3c0 3f 3fe 3ff 0001 1
3 e7 200 222 244 05 010 012 0002 1
2 c3 010 020 030 11 040 04b 0003 1
0 19 3a5 0f0 00f 01 000 000 0002 1

/* test/tbDaq.sv */
module tbDaq;
    logic                      Clk = 1'b0;
    logic                      arstN;
    daqPkg::apbReq_t           apbReq;
    daqPkg::apbRsp_t           apbRsp;
    wire daqPkg::asicPins_t    asicPins;
    logic                      startReadout;
    logic                      dout, transmitOn, endReadout;
    logic [31:0]               eventWord;    // Event the model just sent
    logic                      eventStrobe;

    // Fields of the current pattern line
    logic [31:0] kind, header, dac0, dac1, dac2, ctest;
    logic [31:0] startDac, endDac, acqTime, events;

    logic [31:0]               expEvents[$];       // Every event the model sent
    int                        evIdx = 0;          // First event not yet checked
    logic                      ovfExpected = 1'b0; // Sticky in the DUT too
    int                        curAcqTime = 0;
    int                        acqRun = 0;
    int                        acqWindows = 0;
    int                        shiftBits = 0;
    int                        rstPulses = 0;
    logic [daqPkg::scBits-1:0] shiftCap = '0;
    logic                      srCkLast = 1'b0;
    logic                      srRstbLast = 1'b1;

    always #4 Clk = ~Clk;

    daqTop uut (
        .Clk(Clk), .arstN(arstN),
        .apbReq(apbReq), .apbRsp(apbRsp),
        .asicPins(asicPins), .startReadout(startReadout),
        .dout(dout), .transmitOn(transmitOn), .endReadout(endReadout)
    );

    asicModel asic (
        .Clk(Clk), .startReadout(startReadout),
        .dout(dout), .transmitOn(transmitOn), .endReadout(endReadout),
        .eventWord(eventWord), .eventStrobe(eventStrobe)
    );

    //////////////////////////////////////////////////
    // Monitors
    //////////////////////////////////////////////////
    always @(posedge Clk) begin
        if (eventStrobe) expEvents.push_back(eventWord);
    end

    // ASIC side of the shift samples srIn on srCk rise
    always @(posedge Clk) begin
        srCkLast   <= asicPins.srCk;
        srRstbLast <= asicPins.srRstb;
        if (asicPins.srCk && !srCkLast && asicPins.select) begin
            shiftCap  <= {shiftCap[daqPkg::scBits-2:0], asicPins.srIn};
            shiftBits <= shiftBits + 1;
        end
        if (!asicPins.srRstb && srRstbLast) rstPulses <= rstPulses + 1;  // Falling edge
    end

    // Window length measured when startAcq drops
    always @(posedge Clk) begin
        if (asicPins.startAcq) begin
            assert (!asicPins.select)
            else stopOnError("startAcq went high while the shift register was selected");
            acqRun <= acqRun + 1;
        end else if (acqRun != 0) begin
            assert (acqRun == curAcqTime)
            else stopOnError($sformatf("Error at %0t: startAcq width = %0d, expected %0d",
                                       $time, acqRun, curAcqTime));
            acqWindows <= acqWindows + 1;
            acqRun     <= 0;
        end
    end

    //////////////////////////////////////////////////
    // Helpers
    //////////////////////////////////////////////////
    task automatic stopOnError(input string msg);
        $display("%s", msg);
        $display("sim failed");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic checkValue(input string name, input logic [63:0] got,
                              input logic [63:0] exp);
        assert (got === exp)
        else stopOnError($sformatf("Error at %0t: %s = 0x%0h, expected 0x%0h",
                                   $time, name, got, exp));
    endtask

    // One setup cycle, one access cycle
    task automatic writeReg(input logic [7:0] addr, input logic [31:0] data);
        @(posedge Clk);
        apbReq <= '{psel: 1'b1, penable: 1'b0, pwrite: 1'b1, paddr: addr, pwdata: data};
        @(posedge Clk);
        apbReq.penable <= 1'b1;
        @(posedge Clk);
        apbReq <= '0;
    endtask

    task automatic readReg(input logic [7:0] addr, output logic [31:0] data);
        @(posedge Clk);
        apbReq <= '{psel: 1'b1, penable: 1'b0, pwrite: 1'b0, paddr: addr, pwdata: 32'd0};
        @(posedge Clk);
        apbReq.penable <= 1'b1;
        @(negedge Clk);
        data = apbRsp.prdata;  // Middle of the access cycle
        checkValue("pready", 64'(apbRsp.pready), 64'd1);
        @(posedge Clk);
        apbReq <= '0;
    endtask

    task automatic waitIdle();
        logic [31:0] st;
        int          polls;
        polls = 0;
        readReg(daqPkg::addrStatus, st);
        while (st[0] && polls < 2000) begin
            readReg(daqPkg::addrStatus, st);
            polls++;
        end
        if (st[0]) stopOnError("Timeout: busy did not fall after the operation");
    endtask

    task automatic loadSettings();
        writeReg(daqPkg::addrHeader,  {18'd0, ctest[5:0], header[7:0]});
        writeReg(daqPkg::addrDac0,    {22'd0, dac0[9:0]});
        writeReg(daqPkg::addrDac12,   {6'd0, dac2[9:0], 6'd0, dac1[9:0]});
        writeReg(daqPkg::addrSweep,   {6'd0, endDac[9:0], 6'd0, startDac[9:0]});
        writeReg(daqPkg::addrAcqTime, {16'd0, acqTime[15:0]});
        curAcqTime = int'(acqTime);
    endtask

    task automatic checkReset();
        logic [31:0] st;
        @(negedge Clk);
        checkValue("select", 64'(asicPins.select), 64'd0);
        checkValue("startAcq", 64'(asicPins.startAcq), 64'd0);
        checkValue("srRstb", 64'(asicPins.srRstb), 64'd1);
        readReg(daqPkg::addrStatus, st);
        checkValue("status", 64'(st), 64'd2);  // Idle, empty, no overflow
    endtask

    // Single load shifts exactly the register contents
    task automatic runLoad();
        daqPkg::scConfig_t expCfg;
        logic [31:0]       st;
        int                bitsBefore;
        int                pulsesBefore;
        expCfg = '{header: header[7:0], dac0: dac0[9:0], dac1: dac1[9:0],
                   dac2: dac2[9:0], ctestChannel: ctest[5:0]};
        bitsBefore   = shiftBits;
        pulsesBefore = rstPulses;
        writeReg(daqPkg::addrCtrl, 32'h1);
        waitIdle();
        checkValue("srIn word", 64'(shiftCap), 64'(expCfg));
        checkValue("srCk bits", 64'(shiftBits - bitsBefore), 64'(daqPkg::scBits));
        checkValue("srRstb pulses", 64'(rstPulses - pulsesBefore), 64'd1);
        readReg(daqPkg::addrStatus, st);
        checkValue("status", 64'(st), 64'({29'd0, ovfExpected, 2'b10}));
    endtask

    // Sweep and FIFO drain with an optional restart try while busy
    task automatic runSweep(input logic guard, input logic mustOverflow);
        logic [15:0] expWords[$];
        logic [31:0] st, rd;
        int          steps, limit, code, e, i;
        int          pulsesBefore, windowsBefore;
        steps         = int'(endDac - startDac) + 1;
        pulsesBefore  = rstPulses;
        windowsBefore = acqWindows;
        writeReg(daqPkg::addrCtrl, 32'h2);
        if (guard) begin
            readReg(daqPkg::addrStatus, st);
            checkValue("status.busy", 64'(st[0]), 64'd1);
            writeReg(daqPkg::addrCtrl, 32'h3);  // Has to be ignored
        end
        waitIdle();
        checkValue("readout events", 64'(expEvents.size() - evIdx), 64'(steps * int'(events)));
        checkValue("acquisition windows", 64'(acqWindows - windowsBefore), 64'(steps));
        checkValue("srRstb pulses", 64'(rstPulses - pulsesBefore), 64'(steps));

        // Marker, then each event upper half first
        for (code = int'(startDac); code <= int'(endDac); code++) begin
            expWords.push_back({daqPkg::markerTag, 10'(code)});
            for (e = 0; e < int'(events); e++) begin
                expWords.push_back(expEvents[evIdx][31:16]);
                expWords.push_back(expEvents[evIdx][15:0]);
                evIdx++;
            end
        end
        if (expWords.size() > daqPkg::fifoDepth) ovfExpected = 1'b1;
        if (mustOverflow && expWords.size() <= daqPkg::fifoDepth)
            stopOnError("Overflow pattern does not produce more words than the FIFO holds");
        limit = (expWords.size() > daqPkg::fifoDepth) ? daqPkg::fifoDepth : expWords.size();

        readReg(daqPkg::addrStatus, st);
        checkValue("status", 64'(st), 64'({29'd0, ovfExpected, 2'b00}));
        for (i = 0; i < limit; i++) begin
            readReg(daqPkg::addrFifo, rd);
            checkValue($sformatf("FIFO word %0d", i), 64'(rd), 64'({16'd0, expWords[i]}));
        end
        readReg(daqPkg::addrStatus, st);
        checkValue("status", 64'(st), 64'({29'd0, ovfExpected, 2'b10}));
    endtask

    //////////////////////////////////////////////////
    // Main sequence
    //////////////////////////////////////////////////
    initial begin
        int    fd, got, fields;
        string line;
        apbReq = '0;
        arstN  = 1'b0;
        repeat (4) @(posedge Clk);
        arstN <= 1'b1;
        checkReset();

        fd = $fopen("test/daqPatterns.txt", "r");
        if (fd == 0) stopOnError("Cannot open test/daqPatterns.txt");
        while (!$feof(fd)) begin
            got = $fgets(line, fd);
            if (got > 1 && line.getc(0) != "#") begin  // Skip blanks and comments
                fields = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h",
                                 kind, header, dac0, dac1, dac2, ctest,
                                 startDac, endDac, acqTime, events);
                if (fields != 10) stopOnError($sformatf("Pattern line not understood: %s", line));
                loadSettings();
                case (kind)
                    32'd0:   runLoad();
                    32'd1:   runSweep(1'b0, 1'b0);
                    32'd2:   runSweep(1'b0, 1'b1);
                    32'd3:   runSweep(1'b1, 1'b0);
                    default: stopOnError("Unknown case type in the pattern file");
                endcase
            end
        end
        $fclose(fd);
        $display("sim passed");
        $finish;
    end

endmodule
